// File: hw/pattern_pkg.sv
// Fixed 32-bit register port and 64-bit pattern; FIFO_DEPTH must stay a power of two
package pattern_pkg;

   // =========================================================================
   // Widths
   // =========================================================================

   // Register port word
   localparam int DATA_W        = 32;
   // Input words that make up one pattern
   localparam int PATTERN_WORDS = 2;
   localparam int PATTERN_W     = DATA_W * PATTERN_WORDS;

   // Entries per pattern buffer
   localparam int FIFO_DEPTH    = 16;
   // Count must reach FIFO_DEPTH itself
   localparam int COUNT_W       = $clog2(FIFO_DEPTH + 1);
   // Circular pointers wrap on their own
   localparam int PTR_W         = $clog2(FIFO_DEPTH);

   // Byte address, 128 bytes of register space
   localparam int ADDR_W        = 7;

   // Cycles a buffer stays empty after a clear command
   localparam int CLEAR_HOLD    = 7;
   localparam int HOLD_W        = $clog2(CLEAR_HOLD + 1);

   // =========================================================================
   // Register map
   // =========================================================================

   // Register index is the byte address divided by four
   typedef enum logic [ADDR_W-3:0] {
      REG_FIFO_CTL = 5'd0,
      REG_START    = 5'd1,
      REG_F0_COUNT = 5'd2,
      REG_F1_COUNT = 5'd3,
      REG_INPUT_0  = 5'd16,
      REG_INPUT_1  = 5'd17
   } reg_index_t;

   // Bits of REG_FIFO_CTL; clear bits read back as clear status
   localparam int BIT_F0_CLEAR = 0;
   localparam int BIT_F1_CLEAR = 1;
   localparam int BIT_F0_LOAD  = 2;
   localparam int BIT_F1_LOAD  = 3;

   // Access response, same codes as an AXI response
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_DECERR = 2'd3
   } resp_t;

   // Buffer selection, used for on deck and for the streaming buffer
   typedef enum logic [1:0] {
      SEL_NONE = 2'd0,
      SEL_F0   = 2'd1,
      SEL_F1   = 2'd2
   } fifo_sel_t;

   // Output sequencer states
   typedef enum logic {
      OSM_IDLE   = 1'b0,
      OSM_STREAM = 1'b1
   } osm_state_t;

endpackage

// File: hw/pattern_fifo.sv
// Loads into a full buffer or during clear are dropped; pop and load together need two write ports
`timescale 1ns/1ns

module pattern_fifo (
   input  logic                                  clk,
   input  logic                                  resetn,
   input  logic                                  clear,
   input  logic                                  load,
   input  logic [pattern_pkg::PATTERN_W-1:0]     load_data,
   input  logic                                  pop,
   output logic [pattern_pkg::PATTERN_W-1:0]     head,
   output logic [pattern_pkg::COUNT_W-1:0]       count,
   output logic                                  in_clear
);

   // Pattern store
   logic [pattern_pkg::PATTERN_W-1:0] mem [pattern_pkg::FIFO_DEPTH];

   logic [pattern_pkg::PTR_W-1:0]     rd_ptr;
   logic [pattern_pkg::PTR_W-1:0]     wr_ptr;
   logic [pattern_pkg::PTR_W-1:0]     load_ptr;
   logic [pattern_pkg::COUNT_W-1:0]   count_r;
   logic [pattern_pkg::HOLD_W-1:0]    hold_cnt;
   logic                              full;
   logic                              pop_ok;
   logic                              load_ok;

   // =========================================================================
   // Status
   // =========================================================================

   // Clear strobe cycle plus the remaining hold cycles
   assign in_clear = clear || (hold_cnt != '0);

   // Count reads zero for the whole clear window
   assign count = in_clear ? '0 : count_r;
   assign full  = (count_r == pattern_pkg::FIFO_DEPTH);
   assign head  = mem[rd_ptr];

   assign pop_ok  = pop && !in_clear && (count_r != '0);
   assign load_ok = load && !in_clear && !full;

   // A load in the same cycle as a pop lands behind the recirculated head
   assign load_ptr = pop_ok ? wr_ptr + 1'b1 : wr_ptr;

   // =========================================================================
   // Pointers, count, clear hold
   // =========================================================================

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_ptr   <= '0;
         wr_ptr   <= '0;
         count_r  <= '0;
         hold_cnt <= '0;
      end else if (clear) begin
         rd_ptr   <= '0;
         wr_ptr   <= '0;
         count_r  <= '0;
         // Strobe cycle already counts as the first cycle of the hold
         hold_cnt <= pattern_pkg::HOLD_W'(pattern_pkg::CLEAR_HOLD - 1);
      end else begin
         if (hold_cnt != '0) hold_cnt <= hold_cnt - 1'b1;
         if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
         // Tail moves once per entry written
         case ({pop_ok, load_ok})
            2'b11:        wr_ptr <= wr_ptr + 2'd2;
            2'b10, 2'b01: wr_ptr <= wr_ptr + 1'b1;
            default:      ;
         endcase
         // Recirculation keeps the count, only loads add
         if (load_ok) count_r <= count_r + 1'b1;
      end
   end

   // =========================================================================
   // Store writes
   // =========================================================================

   always_ff @(posedge clk) begin
      // Head goes back to the tail; when full the slot is the same one
      if (pop_ok) mem[wr_ptr] <= mem[rd_ptr];
      if (load_ok) mem[load_ptr] <= load_data;
   end

endmodule

// File: hw/pattern_regs.sv
// Writes are ignored while wbusy is high and then leave wresp as it was; reads are never blocked
`timescale 1ns/1ns

module pattern_regs (
   input  logic                                  clk,
   input  logic                                  resetn,
   // Host write side
   input  logic                                  wr,
   input  logic [pattern_pkg::ADDR_W-1:0]        waddr,
   input  logic [pattern_pkg::DATA_W-1:0]        wdata,
   output pattern_pkg::resp_t                    wresp,
   output logic                                  wbusy,
   // Host read side
   input  logic                                  rd,
   input  logic [pattern_pkg::ADDR_W-1:0]        raddr,
   output logic [pattern_pkg::DATA_W-1:0]        rdata,
   output pattern_pkg::resp_t                    rresp,
   // Buffer status
   input  logic [pattern_pkg::COUNT_W-1:0]       f0_count,
   input  logic [pattern_pkg::COUNT_W-1:0]       f1_count,
   input  logic                                  f0_in_clear,
   input  logic                                  f1_in_clear,
   input  pattern_pkg::fifo_sel_t                active,
   // Buffer control
   output logic                                  f0_clear,
   output logic                                  f1_clear,
   output logic                                  f0_load,
   output logic                                  f1_load,
   output logic [pattern_pkg::PATTERN_W-1:0]     load_data,
   output pattern_pkg::fifo_sel_t                on_deck
);

   // Register indices, low two address bits dropped
   logic [pattern_pkg::ADDR_W-3:0] windex;
   logic [pattern_pkg::ADDR_W-3:0] rindex;
   logic                           wr_ok;
   logic [pattern_pkg::DATA_W-1:0] rd_word;
   logic                           rd_hit;

   assign windex = waddr[pattern_pkg::ADDR_W-1:2];
   assign rindex = raddr[pattern_pkg::ADDR_W-1:2];

   // Busy for as long as either buffer is held in clear
   assign wbusy = f0_in_clear | f1_in_clear;
   assign wr_ok = wr && !wbusy;

   // =========================================================================
   // Write side
   // =========================================================================

   // Strobes, on-deck selection and write response
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wresp    <= pattern_pkg::RESP_OKAY;
         f0_clear <= 1'b0;
         f1_clear <= 1'b0;
         f0_load  <= 1'b0;
         f1_load  <= 1'b0;
         on_deck  <= pattern_pkg::SEL_NONE;
      end else begin
         // Strobes last a single cycle
         f0_clear <= 1'b0;
         f1_clear <= 1'b0;
         f0_load  <= 1'b0;
         f1_load  <= 1'b0;
         if (wr_ok) begin
            wresp <= pattern_pkg::RESP_OKAY;
            case (windex)
               pattern_pkg::REG_FIFO_CTL: begin
                  f0_clear <= wdata[pattern_pkg::BIT_F0_CLEAR];
                  f1_clear <= wdata[pattern_pkg::BIT_F1_CLEAR];
                  f0_load  <= wdata[pattern_pkg::BIT_F0_LOAD];
                  f1_load  <= wdata[pattern_pkg::BIT_F1_LOAD];
               end
               // Both start bits at once is not a valid selection
               pattern_pkg::REG_START:
                  if (wdata[1:0] != 2'b11) on_deck <= pattern_pkg::fifo_sel_t'(wdata[1:0]);
               // Counts are read-only, a write is accepted and dropped
               pattern_pkg::REG_F0_COUNT, pattern_pkg::REG_F1_COUNT: ;
               pattern_pkg::REG_INPUT_0, pattern_pkg::REG_INPUT_1: ;
               default: wresp <= pattern_pkg::RESP_DECERR;
            endcase
         end
      end
   end

   // Pattern words, low word at REG_INPUT_0
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         case (windex)
            pattern_pkg::REG_INPUT_0: load_data[0*pattern_pkg::DATA_W +: pattern_pkg::DATA_W] <= wdata;
            pattern_pkg::REG_INPUT_1: load_data[1*pattern_pkg::DATA_W +: pattern_pkg::DATA_W] <= wdata;
            default: ;
         endcase
      end
   end

   // =========================================================================
   // Read side
   // =========================================================================

   // Read mux, narrow fields zero-extended
   always_comb begin
      rd_word = '0;
      rd_hit  = 1'b1;
      case (rindex)
         pattern_pkg::REG_FIFO_CTL: rd_word[1:0] = {f1_in_clear, f0_in_clear};
         pattern_pkg::REG_START:    rd_word[1:0] = active;
         pattern_pkg::REG_F0_COUNT: rd_word[pattern_pkg::COUNT_W-1:0] = f0_count;
         pattern_pkg::REG_F1_COUNT: rd_word[pattern_pkg::COUNT_W-1:0] = f1_count;
         pattern_pkg::REG_INPUT_0:  rd_word = load_data[0*pattern_pkg::DATA_W +: pattern_pkg::DATA_W];
         pattern_pkg::REG_INPUT_1:  rd_word = load_data[1*pattern_pkg::DATA_W +: pattern_pkg::DATA_W];
         default:                   rd_hit  = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rresp <= pattern_pkg::RESP_OKAY;
      end else if (rd) begin
         rresp <= rd_hit ? pattern_pkg::RESP_OKAY : pattern_pkg::RESP_DECERR;
      end
   end

   // Read data held until the next read
   always_ff @(posedge clk) begin
      if (rd) rdata <= rd_word;
   end

endmodule

// File: hw/pattern_sequencer.sv
// Frame length is latched at frame start; clearing the streaming buffer mid-frame yields stale data
`timescale 1ns/1ns

module pattern_sequencer (
   input  logic                                  clk,
   input  logic                                  resetn,
   input  pattern_pkg::fifo_sel_t                on_deck,
   input  logic [pattern_pkg::COUNT_W-1:0]       f0_count,
   input  logic [pattern_pkg::COUNT_W-1:0]       f1_count,
   input  logic [pattern_pkg::PATTERN_W-1:0]     f0_head,
   input  logic [pattern_pkg::PATTERN_W-1:0]     f1_head,
   // Output stream
   output logic [pattern_pkg::PATTERN_W-1:0]     out_tdata,
   output logic                                  out_tvalid,
   input  logic                                  out_tready,
   // Streaming buffer and recirculation pops
   output pattern_pkg::fifo_sel_t                active,
   output logic                                  f0_pop,
   output logic                                  f1_pop
);

   pattern_pkg::osm_state_t          state;
   // Beats still to go in the current frame
   logic [pattern_pkg::COUNT_W-1:0]  beats_left;
   logic                             handshake;
   logic                             boundary;

   assign handshake = out_tvalid && out_tready;

   // Idle, or the last beat of a frame is leaving
   assign boundary = (state == pattern_pkg::OSM_IDLE) || (handshake && (beats_left == 1));

   // Each beat that leaves goes back to its buffer's tail
   assign f0_pop = handshake && (active == pattern_pkg::SEL_F0);
   assign f1_pop = handshake && (active == pattern_pkg::SEL_F1);

   // Data straight from the streaming buffer's head
   always_comb begin
      case (active)
         pattern_pkg::SEL_F0: out_tdata = f0_head;
         pattern_pkg::SEL_F1: out_tdata = f1_head;
         default:             out_tdata = '0;
      endcase
   end

   // =========================================================================
   // Frame FSM
   // =========================================================================

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state      <= pattern_pkg::OSM_IDLE;
         active     <= pattern_pkg::SEL_NONE;
         out_tvalid <= 1'b0;
         beats_left <= '0;
      end else if (boundary) begin
         // on_deck is only looked at here, so a switch waits for frame end
         if (on_deck == pattern_pkg::SEL_F0 && f0_count != '0) begin
            state      <= pattern_pkg::OSM_STREAM;
            active     <= pattern_pkg::SEL_F0;
            beats_left <= f0_count;
            out_tvalid <= 1'b1;
         end else if (on_deck == pattern_pkg::SEL_F1 && f1_count != '0) begin
            state      <= pattern_pkg::OSM_STREAM;
            active     <= pattern_pkg::SEL_F1;
            beats_left <= f1_count;
            out_tvalid <= 1'b1;
         end else begin
            // Nothing to send, wait in idle
            state      <= pattern_pkg::OSM_IDLE;
            active     <= pattern_pkg::SEL_NONE;
            out_tvalid <= 1'b0;
         end
      end else if (handshake) begin
         beats_left <= beats_left - 1'b1;
      end
      // Back-pressure: everything holds
   end

endmodule

// File: hw/pattern_ctrl.sv
// Plain strobe register port, no AXI core; two recirculating buffers feed one valid/ready stream
`timescale 1ns/1ns

module pattern_ctrl (
   input  logic                                  clk,
   input  logic                                  resetn,
   // Register port
   input  logic                                  wr,
   input  logic [pattern_pkg::ADDR_W-1:0]        waddr,
   input  logic [pattern_pkg::DATA_W-1:0]        wdata,
   output pattern_pkg::resp_t                    wresp,
   output logic                                  wbusy,
   input  logic                                  rd,
   input  logic [pattern_pkg::ADDR_W-1:0]        raddr,
   output logic [pattern_pkg::DATA_W-1:0]        rdata,
   output pattern_pkg::resp_t                    rresp,
   // Output stream
   output logic [pattern_pkg::PATTERN_W-1:0]     out_tdata,
   output logic                                  out_tvalid,
   input  logic                                  out_tready
);

   // =========================================================================
   // Internal wiring
   // =========================================================================

   logic                              f0_clear, f1_clear;
   logic                              f0_load, f1_load;
   logic [pattern_pkg::PATTERN_W-1:0] load_data;
   pattern_pkg::fifo_sel_t            on_deck;
   pattern_pkg::fifo_sel_t            active;
   logic [pattern_pkg::COUNT_W-1:0]   f0_count, f1_count;
   logic                              f0_in_clear, f1_in_clear;
   logic [pattern_pkg::PATTERN_W-1:0] f0_head, f1_head;
   logic                              f0_pop, f1_pop;

   // Register decode and buffer control
   pattern_regs regs0 (
      .clk, .resetn,
      .wr, .waddr, .wdata, .wresp, .wbusy,
      .rd, .raddr, .rdata, .rresp,
      .f0_count, .f1_count, .f0_in_clear, .f1_in_clear, .active,
      .f0_clear, .f1_clear, .f0_load, .f1_load, .load_data, .on_deck
   );

   // Both buffers share the pattern bus
   pattern_fifo fifo_0 (
      .clk, .resetn,
      .clear(f0_clear), .load(f0_load), .load_data, .pop(f0_pop),
      .head(f0_head), .count(f0_count), .in_clear(f0_in_clear)
   );

   pattern_fifo fifo_1 (
      .clk, .resetn,
      .clear(f1_clear), .load(f1_load), .load_data, .pop(f1_pop),
      .head(f1_head), .count(f1_count), .in_clear(f1_in_clear)
   );

   // Frames from the on-deck buffer
   pattern_sequencer seq0 (
      .clk, .resetn,
      .on_deck, .f0_count, .f1_count, .f0_head, .f1_head,
      .out_tdata, .out_tvalid, .out_tready,
      .active, .f0_pop, .f1_pop
   );

endmodule

// File: dv/pattern_ctrl_assert.sv
// Clear-hold property assumes the two buffers are never cleared in overlapping windows
`timescale 1ns/1ns

module pattern_ctrl_assert (
   input logic                                  clk,
   input logic                                  resetn,
   input logic                                  out_tvalid,
   input logic                                  out_tready,
   input logic [pattern_pkg::PATTERN_W-1:0]     out_tdata,
   input logic                                  wbusy,
   input pattern_pkg::fifo_sel_t                active,
   input logic [pattern_pkg::COUNT_W-1:0]       beats_left
);

   // Failures seen so far
   int fail_count = 0;

   // Stream, selection and busy all quiet after a reset edge
   a_reset_idle: assert property (@(posedge clk)
      !resetn |=> !out_tvalid && active == pattern_pkg::SEL_NONE && !wbusy)
      else begin
         fail_count++;
         $error("stream or busy active after a reset cycle");
      end

   // Stalled beat holds its data and the frame counter
   a_backpressure: assert property (@(posedge clk) disable iff (!resetn)
      out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(beats_left))
      else begin
         fail_count++;
         $error("stalled beat changed under back-pressure");
      end

   // Busy window is exactly the clear hold
   a_clear_hold: assert property (@(posedge clk) disable iff (!resetn)
      $rose(wbusy) |-> wbusy [*pattern_pkg::CLEAR_HOLD] ##1 !wbusy)
      else begin
         fail_count++;
         $error("wbusy length differs from the clear hold");
      end

endmodule

bind pattern_ctrl pattern_ctrl_assert assert0 (
   .clk, .resetn, .out_tvalid, .out_tready, .out_tdata, .wbusy,
   .active,
   .beats_left(seq0.beats_left)
);

// File: dv/pattern_ctrl_tb.sv
// Model assumes the streaming buffer is never cleared or loaded mid-frame; run capped at 4000 cycles
`timescale 1ns/1ns

module pattern_ctrl_tb;

   // Script needs well under 2000 cycles with random ready, limit is about twice that
   localparam int TIMEOUT_CYCLES = 4000;

   logic                               clk;
   logic                               resetn;
   logic                               wr;
   logic                               rd;
   logic [pattern_pkg::ADDR_W-1:0]     waddr;
   logic [pattern_pkg::ADDR_W-1:0]     raddr;
   logic [pattern_pkg::DATA_W-1:0]     wdata;
   logic [pattern_pkg::DATA_W-1:0]     rdata;
   pattern_pkg::resp_t                 wresp;
   pattern_pkg::resp_t                 rresp;
   logic                               wbusy;
   logic [pattern_pkg::PATTERN_W-1:0]  out_tdata;
   logic                               out_tvalid;
   logic                               out_tready;

   // Reference model, one queue per buffer in stream order
   logic [pattern_pkg::PATTERN_W-1:0]  q0[$];
   logic [pattern_pkg::PATTERN_W-1:0]  q1[$];
   pattern_pkg::fifo_sel_t             m_on_deck;
   pattern_pkg::fifo_sel_t             m_active;
   logic                               m_valid;
   logic                               m_pend0;
   logic                               m_pend1;
   logic [pattern_pkg::PATTERN_W-1:0]  m_pend_data;
   logic [pattern_pkg::DATA_W-1:0]     m_in0;
   logic [pattern_pkg::DATA_W-1:0]     m_in1;
   int                                 m_left;
   int                                 m_hold0;
   int                                 m_hold1;

   int          tb_errors = 0;
   int          beat_count = 0;
   int          cycles = 0;
   logic [7:0]  lfsr = 8'd35;

   pattern_ctrl dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   function automatic logic [pattern_pkg::ADDR_W-1:0] reg_addr(input int index);
      return pattern_pkg::ADDR_W'(index * 4);
   endfunction

   // Buffer id in the top byte, load number below it and in the low word
   function automatic logic [pattern_pkg::PATTERN_W-1:0] make_pattern(input int buf_id,
                                                                      input int k);
      return {4'hA, 4'(buf_id), 24'(k), 32'h5EED_0000 | 32'(k)};
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         tb_errors++;
         $display("CHECK FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic write_reg(input logic [pattern_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] data, input pattern_pkg::resp_t exp_resp);
      while (wbusy) step_cycle();
      wr    = 1'b1;
      waddr = addr;
      wdata = data;
      step_cycle();
      wr = 1'b0;
      check_value("wresp", wresp, exp_resp);
   endtask

   // Data is compared only for mapped registers
   task automatic read_expect(input logic [pattern_pkg::ADDR_W-1:0] addr,
                              input logic [31:0] exp_data,
                              input pattern_pkg::resp_t exp_resp, input string name);
      while (wbusy) step_cycle();
      rd    = 1'b1;
      raddr = addr;
      step_cycle();
      rd = 1'b0;
      check_value({name, " rresp"}, rresp, exp_resp);
      if (exp_resp == pattern_pkg::RESP_OKAY) check_value(name, rdata, exp_data);
   endtask

   // Count shows up two cycles after the load write
   task automatic load_pattern(input int buf_id, input logic [63:0] pat);
      write_reg(reg_addr(pattern_pkg::REG_INPUT_0), pat[31:0], pattern_pkg::RESP_OKAY);
      write_reg(reg_addr(pattern_pkg::REG_INPUT_1), pat[63:32], pattern_pkg::RESP_OKAY);
      write_reg(reg_addr(pattern_pkg::REG_FIFO_CTL), 32'(1) << (pattern_pkg::BIT_F0_LOAD + buf_id),
                pattern_pkg::RESP_OKAY);
      step_cycle();
   endtask

   task automatic wait_beats(input int n);
      int target;
      target = beat_count + n;
      while (beat_count < target) step_cycle();
   endtask

   // Random back-pressure, one LFSR step per ready bit
   always @(posedge clk) begin
      #1;
      if (!resetn) begin
         out_tready = 1'b0;
      end else begin
         lfsr       = lfsr_next(lfsr);
         out_tready = lfsr[0];
      end
   end

   // ==========================================================================
   // Reference model, evaluated mid-cycle for the coming rising edge
   // ==========================================================================

   always @(negedge clk) begin
      logic                           busy;
      logic                           hs;
      logic                           last;
      logic [63:0]                    beat;
      logic [pattern_pkg::ADDR_W-3:0] idx;
      if (!resetn) begin
         q0.delete();
         q1.delete();
         m_on_deck = pattern_pkg::SEL_NONE;
         m_active  = pattern_pkg::SEL_NONE;
         m_valid   = 1'b0;
         m_pend0   = 1'b0;
         m_pend1   = 1'b0;
         m_left    = 0;
         m_hold0   = 0;
         m_hold1   = 0;
      end else begin
         busy = (m_hold0 != 0) || (m_hold1 != 0);
         check_value("wbusy", wbusy, busy);
         check_value("out_tvalid", out_tvalid, m_valid);
         if (m_valid && m_active == pattern_pkg::SEL_F0 && q0.size() != 0)
            check_value("out_tdata", out_tdata, q0[0]);
         if (m_valid && m_active == pattern_pkg::SEL_F1 && q1.size() != 0)
            check_value("out_tdata", out_tdata, q1[0]);
         // Beat leaves and goes back to the tail of its queue
         hs   = m_valid && out_tready;
         last = hs && (m_left == 1);
         if (hs) begin
            beat_count++;
            m_left--;
            if (m_active == pattern_pkg::SEL_F0) begin
               beat = q0.pop_front();
               q0.push_back(beat);
            end else begin
               beat = q1.pop_front();
               q1.push_back(beat);
            end
         end
         // Frame boundary, length is the queue size right now
         if (!m_valid || last) begin
            m_valid = 1'b1;
            if (m_on_deck == pattern_pkg::SEL_F0 && q0.size() != 0) begin
               m_active = pattern_pkg::SEL_F0;
               m_left   = q0.size();
            end else if (m_on_deck == pattern_pkg::SEL_F1 && q1.size() != 0) begin
               m_active = pattern_pkg::SEL_F1;
               m_left   = q1.size();
            end else begin
               m_active = pattern_pkg::SEL_NONE;
               m_valid  = 1'b0;
            end
         end
         // Load strobes of the previous write, dropped when full
         if (m_pend0 && q0.size() < pattern_pkg::FIFO_DEPTH) q0.push_back(m_pend_data);
         if (m_pend1 && q1.size() < pattern_pkg::FIFO_DEPTH) q1.push_back(m_pend_data);
         m_pend0 = 1'b0;
         m_pend1 = 1'b0;
         if (m_hold0 != 0) m_hold0--;
         if (m_hold1 != 0) m_hold1--;
         // Host write taken at this edge
         if (wr && !busy) begin
            idx = waddr[pattern_pkg::ADDR_W-1:2];
            if (idx == pattern_pkg::REG_INPUT_0) begin
               m_in0 = wdata;
            end else if (idx == pattern_pkg::REG_INPUT_1) begin
               m_in1 = wdata;
            end else if (idx == pattern_pkg::REG_START && wdata[1:0] != 2'b11) begin
               m_on_deck = pattern_pkg::fifo_sel_t'(wdata[1:0]);
            end else if (idx == pattern_pkg::REG_FIFO_CTL) begin
               if (wdata[pattern_pkg::BIT_F0_CLEAR]) begin
                  q0.delete();
                  m_hold0 = pattern_pkg::CLEAR_HOLD;
               end
               if (wdata[pattern_pkg::BIT_F1_CLEAR]) begin
                  q1.delete();
                  m_hold1 = pattern_pkg::CLEAR_HOLD;
               end
               m_pend0     = wdata[pattern_pkg::BIT_F0_LOAD];
               m_pend1     = wdata[pattern_pkg::BIT_F1_LOAD];
               m_pend_data = {m_in1, m_in0};
            end
         end
      end
   end

   // ==========================================================================
   // Script
   // ==========================================================================

   initial begin
      int k;
      resetn = 1'b0;
      wr     = 1'b0;
      rd     = 1'b0;
      waddr  = '0;
      raddr  = '0;
      wdata  = '0;
      out_tready = 1'b0;
      repeat (16) @(posedge clk);
      #1 resetn = 1'b1;

      // Readback, then an unmapped index that must change nothing
      write_reg(reg_addr(pattern_pkg::REG_INPUT_0), 32'hCAFE_0001, pattern_pkg::RESP_OKAY);
      write_reg(reg_addr(pattern_pkg::REG_INPUT_1), 32'h0BAD_F00D, pattern_pkg::RESP_OKAY);
      read_expect(reg_addr(pattern_pkg::REG_INPUT_0), 32'hCAFE_0001, pattern_pkg::RESP_OKAY,
                  "rdata INPUT_0");
      read_expect(reg_addr(pattern_pkg::REG_INPUT_1), 32'h0BAD_F00D, pattern_pkg::RESP_OKAY,
                  "rdata INPUT_1");
      write_reg(reg_addr(8), 32'hFFFF_FFFF, pattern_pkg::RESP_DECERR);
      read_expect(reg_addr(8), '0, pattern_pkg::RESP_DECERR, "rdata unmapped");
      read_expect(reg_addr(pattern_pkg::REG_INPUT_0), 32'hCAFE_0001, pattern_pkg::RESP_OKAY,
                  "rdata INPUT_0");
      read_expect(reg_addr(pattern_pkg::REG_INPUT_1), 32'h0BAD_F00D, pattern_pkg::RESP_OKAY,
                  "rdata INPUT_1");

      // Four patterns in F0, F1 overfilled past its depth
      for (k = 1; k <= 4; k++) begin
         load_pattern(0, make_pattern(0, k));
         read_expect(reg_addr(pattern_pkg::REG_F0_COUNT), k, pattern_pkg::RESP_OKAY,
                     "rdata F0_COUNT");
      end
      for (k = 1; k <= pattern_pkg::FIFO_DEPTH + 2; k++) begin
         load_pattern(1, make_pattern(1, k));
         read_expect(reg_addr(pattern_pkg::REG_F1_COUNT),
                     (k < pattern_pkg::FIFO_DEPTH) ? k : pattern_pkg::FIFO_DEPTH,
                     pattern_pkg::RESP_OKAY, "rdata F1_COUNT");
      end

      // F0 recirculates for three frames
      write_reg(reg_addr(pattern_pkg::REG_START), 32'd1, pattern_pkg::RESP_OKAY);
      wait_beats(12);
      read_expect(reg_addr(pattern_pkg::REG_START), pattern_pkg::SEL_F0,
                  pattern_pkg::RESP_OKAY, "rdata START");

      // Switch to F1 with two F0 beats still owed
      while (!(m_valid && m_active == pattern_pkg::SEL_F0 && m_left == 2)) step_cycle();
      write_reg(reg_addr(pattern_pkg::REG_START), 32'd2, pattern_pkg::RESP_OKAY);
      wait_beats(20);
      read_expect(reg_addr(pattern_pkg::REG_START), pattern_pkg::SEL_F1,
                  pattern_pkg::RESP_OKAY, "rdata START");
      write_reg(reg_addr(pattern_pkg::REG_START), 32'd3, pattern_pkg::RESP_OKAY);
      wait_beats(20);
      read_expect(reg_addr(pattern_pkg::REG_START), pattern_pkg::SEL_F1,
                  pattern_pkg::RESP_OKAY, "rdata START");

      // Clear idle F0, then put the empty buffer on deck
      write_reg(reg_addr(pattern_pkg::REG_FIFO_CTL), 32'(1) << pattern_pkg::BIT_F0_CLEAR,
                pattern_pkg::RESP_OKAY);
      read_expect(reg_addr(pattern_pkg::REG_F0_COUNT), '0, pattern_pkg::RESP_OKAY,
                  "rdata F0_COUNT");
      write_reg(reg_addr(pattern_pkg::REG_START), 32'd1, pattern_pkg::RESP_OKAY);
      while (m_valid) step_cycle();
      // Quiet window, the model checks tvalid on every cycle of it
      repeat (10) step_cycle();
      check_value("out_tvalid", out_tvalid, 1'b0);
      read_expect(reg_addr(pattern_pkg::REG_START), pattern_pkg::SEL_NONE,
                  pattern_pkg::RESP_OKAY, "rdata START");

      $display("Summary: %0d check errors, %0d assertion errors, %0d beats, %0d cycles",
               tb_errors, dut0.assert0.fail_count, beat_count, cycles);
      if (tb_errors == 0 && dut0.assert0.fail_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("ERROR: run did not finish within %0d cycles, %0d beats seen",
                  TIMEOUT_CYCLES, beat_count);
         $display("TEST FAIL");
         $finish;
      end
   end

endmodule

// File: compile.f
hw/pattern_pkg.sv
hw/pattern_fifo.sv
hw/pattern_regs.sv
hw/pattern_sequencer.sv
hw/pattern_ctrl.sv
dv/pattern_ctrl_assert.sv
dv/pattern_ctrl_tb.sv

// File: Bender.yml
package:
  name: pattern_ctrl

sources:
  - files:
      - hw/pattern_pkg.sv
      - hw/pattern_fifo.sv
      - hw/pattern_regs.sv
      - hw/pattern_sequencer.sv
      - hw/pattern_ctrl.sv
  - target: simulation
    files:
      - dv/pattern_ctrl_assert.sv
      - dv/pattern_ctrl_tb.sv
